// File: adc_deser/adc_deser.sv
module adc_deser (
    input  logic                     ADC_CLK,
    input  logic                     RST,
    input  logic                     fco,
    input  logic                     serial_in,
    output adc_rx_pkg::chan_sample_t sample
);

    localparam logic [3:0] LAST_BIT = 4'(adc_rx_pkg::SAMPLE_W - 1);
    localparam logic [3:0] IDLE_CNT = 4'(adc_rx_pkg::SAMPLE_W);

    logic                      in_q;
    logic                      fco_q;
    logic                      fco_qq;
    logic                      frame_start;
    logic [3:0]                bit_cnt;
    adc_rx_pkg::sample_t       shift_reg;

    // input register stage
    always_ff @(posedge ADC_CLK) begin
        in_q   <= serial_in;
        fco_q  <= fco;
        fco_qq <= fco_q;
    end

    assign frame_start = fco_q & ~fco_qq;

    // msb first
    always_ff @(posedge ADC_CLK) begin
        shift_reg <= {shift_reg[adc_rx_pkg::SAMPLE_W-2:0], in_q};
    end

    // counter parks at IDLE_CNT between frames so gaps give no extra valid
    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            bit_cnt <= IDLE_CNT;
        end else if (frame_start) begin
            bit_cnt <= 4'd0;
        end else if (bit_cnt != IDLE_CNT) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    assign sample.valid = (bit_cnt == LAST_BIT);
    assign sample.data  = shift_reg;

endmodule

// File: common/adc_rx_pkg.sv
package adc_rx_pkg;

    localparam int SAMPLE_W = 14;
    localparam int FIFO_AW  = 6;   // 64 words

    // word addresses of the register map
    localparam logic [3:0] REG_SOFT_RST   = 4'd0;
    localparam logic [3:0] REG_START      = 4'd1;
    localparam logic [3:0] REG_CONF       = 4'd2;
    localparam logic [3:0] REG_DATA_CNT   = 4'd3;
    localparam logic [3:0] REG_SKIP       = 4'd4;
    localparam logic [3:0] REG_DELAY      = 4'd5;
    localparam logic [3:0] REG_LOST       = 4'd6;
    localparam logic [3:0] REG_FIFO_DATA  = 4'd7;
    localparam logic [3:0] REG_FIFO_LEVEL = 4'd8;

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic    valid;
        sample_t data;
    } chan_sample_t;

    typedef struct packed {
        logic        start_with_sync;
        logic        pair_mode;
        logic        chan_sel;       // 1 selects channel B in single mode
        logic [15:0] data_cnt;       // 0 runs forever
        logic [7:0]  skip;
        logic [7:0]  delay;
    } rx_cfg_t;

    localparam rx_cfg_t CFG_RESET = '{
        start_with_sync: 1'b0,
        pair_mode:       1'b0,
        chan_sel:        1'b0,
        data_cnt:        16'd0,
        skip:            8'd1,
        delay:           8'd0
    };

    typedef struct packed {
        logic       done;
        logic [7:0] lost_cnt;   // saturates at 255
    } rx_status_t;

    typedef struct packed {
        logic       fmt;        // 1 here
        logic       sync;
        logic [1:0] tag;
        sample_t    smp_b;
        sample_t    smp_a;
    } pair_word_t;

    typedef struct packed {
        logic        fmt;       // 0 here
        logic        sync;
        logic [1:0]  tag;
        logic [12:0] zero;
        logic        chan;
        sample_t     smp;
    } single_word_t;

    typedef union packed {
        pair_word_t   pair;
        single_word_t single_ch;
    } adc_word_u;

endpackage

// File: logic/adc_rx_regs.sv
module adc_rx_regs (
    input  logic                          ADC_CLK,
    input  logic                          RST,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [3:0]                    wb_adr,
    input  logic [31:0]                   wb_wdata,
    output logic [31:0]                   wb_rdata,
    output logic                          wb_ack,
    output adc_rx_pkg::rx_cfg_t           cfg,
    output logic                          soft_rst,
    output logic                          start,
    input  adc_rx_pkg::rx_status_t        status,
    input  adc_rx_pkg::adc_word_u         fifo_rdata,
    input  logic                          fifo_empty,
    input  logic [adc_rx_pkg::FIFO_AW:0]  fifo_level,
    output logic                          fifo_pop
);

    logic        req;
    logic        served;
    logic        first;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] rd_mux;

    assign req   = wb_cyc & wb_stb;
    assign first = req & ~wb_ack & ~served;   // one access per strobe
    assign wr_en = first & wb_we;
    assign rd_en = first & ~wb_we;

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            wb_ack <= 1'b0;
            served <= 1'b0;
        end else begin
            wb_ack <= first;
            served <= req & (served | wb_ack);  // hold off until stb drops
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            soft_rst <= 1'b0;
            start    <= 1'b0;
        end else begin
            soft_rst <= wr_en && wb_adr == adc_rx_pkg::REG_SOFT_RST;
            start    <= wr_en && wb_adr == adc_rx_pkg::REG_START;
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            cfg <= adc_rx_pkg::CFG_RESET;
        end else if (wr_en) begin
            case (wb_adr)
                adc_rx_pkg::REG_CONF: begin
                    cfg.start_with_sync <= wb_wdata[0];
                    cfg.pair_mode       <= wb_wdata[1];
                    cfg.chan_sel        <= wb_wdata[2];
                end
                adc_rx_pkg::REG_DATA_CNT: cfg.data_cnt <= wb_wdata[15:0];
                adc_rx_pkg::REG_SKIP:     cfg.skip     <= wb_wdata[7:0];
                adc_rx_pkg::REG_DELAY:    cfg.delay    <= wb_wdata[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (wb_adr)
            adc_rx_pkg::REG_START:      rd_mux = {31'd0, status.done};
            adc_rx_pkg::REG_CONF:       rd_mux = {29'd0, cfg.chan_sel, cfg.pair_mode,
                                                  cfg.start_with_sync};
            adc_rx_pkg::REG_DATA_CNT:   rd_mux = {16'd0, cfg.data_cnt};
            adc_rx_pkg::REG_SKIP:       rd_mux = {24'd0, cfg.skip};
            adc_rx_pkg::REG_DELAY:      rd_mux = {24'd0, cfg.delay};
            adc_rx_pkg::REG_LOST:       rd_mux = {24'd0, status.lost_cnt};
            adc_rx_pkg::REG_FIFO_DATA:  rd_mux = fifo_empty ? 32'd0 : fifo_rdata;
            adc_rx_pkg::REG_FIFO_LEVEL: rd_mux = 32'(fifo_level);
            default:                    rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge ADC_CLK) begin
        if (rd_en)
            wb_rdata <= rd_mux;
    end

    // head word leaves on the same edge that raises ack
    assign fifo_pop = rd_en && wb_adr == adc_rx_pkg::REG_FIFO_DATA && !fifo_empty;

endmodule

// File: logic/adc_rx_top.sv
module adc_rx_top (
    input  logic        ADC_CLK,
    input  logic        RST,
    input  logic        adc_fco,
    input  logic        adc_in_a,
    input  logic        adc_in_b,
    input  logic        adc_sync,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [3:0]  wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack,
    output logic        lost_error
);

    adc_rx_pkg::chan_sample_t         smp_a;
    adc_rx_pkg::chan_sample_t         smp_b;
    adc_rx_pkg::rx_cfg_t              cfg;
    adc_rx_pkg::rx_status_t           status;
    adc_rx_pkg::adc_word_u            push_word;
    adc_rx_pkg::adc_word_u            fifo_rdata;
    logic                             soft_rst;
    logic                             start;
    logic                             push;
    logic                             fifo_pop;
    logic                             fifo_full;
    logic                             fifo_empty;
    logic [adc_rx_pkg::FIFO_AW:0]     fifo_level;

    // both channels share the frame clock
    adc_deser u_deser_a (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .fco       (adc_fco),
        .serial_in (adc_in_a),
        .sample    (smp_a)
    );

    adc_deser u_deser_b (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .fco       (adc_fco),
        .serial_in (adc_in_b),
        .sample    (smp_b)
    );

    sample_packer u_packer (
        .ADC_CLK   (ADC_CLK),
        .RST       (RST),
        .soft_rst  (soft_rst),
        .start     (start),
        .cfg       (cfg),
        .chan_a    (smp_a),
        .chan_b    (smp_b),
        .sync_in   (adc_sync),
        .fifo_full (fifo_full),
        .push      (push),
        .word      (push_word),
        .status    (status)
    );

    rx_fifo u_fifo (
        .ADC_CLK (ADC_CLK),
        .RST     (RST),
        .clear   (soft_rst),
        .push    (push),
        .wdata   (push_word),
        .pop     (fifo_pop),
        .rdata   (fifo_rdata),
        .full    (fifo_full),
        .empty   (fifo_empty),
        .level   (fifo_level)
    );

    adc_rx_regs u_regs (
        .ADC_CLK    (ADC_CLK),
        .RST        (RST),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .cfg        (cfg),
        .soft_rst   (soft_rst),
        .start      (start),
        .status     (status),
        .fifo_rdata (fifo_rdata),
        .fifo_empty (fifo_empty),
        .fifo_level (fifo_level),
        .fifo_pop   (fifo_pop)
    );

    assign lost_error = (status.lost_cnt != 8'd0);

endmodule

// File: logic/rx_fifo.sv
module rx_fifo (
    input  logic                          ADC_CLK,
    input  logic                          RST,
    input  logic                          clear,
    input  logic                          push,
    input  adc_rx_pkg::adc_word_u         wdata,
    input  logic                          pop,
    output adc_rx_pkg::adc_word_u         rdata,
    output logic                          full,
    output logic                          empty,
    output logic [adc_rx_pkg::FIFO_AW:0]  level
);

    localparam int DEPTH = 1 << adc_rx_pkg::FIFO_AW;

    adc_rx_pkg::adc_word_u            mem [DEPTH];
    logic [adc_rx_pkg::FIFO_AW-1:0]   wr_ptr;
    logic [adc_rx_pkg::FIFO_AW-1:0]   rd_ptr;
    logic                             do_push;
    logic                             do_pop;

    assign full    = (level == (adc_rx_pkg::FIFO_AW + 1)'(DEPTH));
    assign empty   = (level == '0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge ADC_CLK) begin
        if (do_push)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                level <= level + 1'b1;
            else if (do_pop && !do_push)
                level <= level - 1'b1;
        end
    end

    assign rdata = mem[rd_ptr];  // show-ahead

endmodule

// File: logic/sample_packer.sv
module sample_packer (
    input  logic                     ADC_CLK,
    input  logic                     RST,
    input  logic                     soft_rst,
    input  logic                     start,
    input  adc_rx_pkg::rx_cfg_t      cfg,
    input  adc_rx_pkg::chan_sample_t chan_a,
    input  adc_rx_pkg::chan_sample_t chan_b,
    input  logic                     sync_in,
    input  logic                     fifo_full,
    output logic                     push,
    output adc_rx_pkg::adc_word_u    word,
    output adc_rx_pkg::rx_status_t   status
);

    logic        clr;
    logic        sync_q;
    logic        sync_rise;
    logic        wait_sync;
    logic        rec_start;
    logic        active;
    logic        accept;
    logic        done;
    logic [7:0]  frame_cnt;
    logic [7:0]  lost_cnt;
    logic [15:0] rec_cnt;

    assign clr       = RST | soft_rst;
    assign sync_rise = sync_in & ~sync_q;
    assign rec_start = cfg.start_with_sync ? (wait_sync & sync_rise) : start;
    assign accept    = chan_a.valid & active & (frame_cnt == cfg.delay);

    always_ff @(posedge ADC_CLK) begin
        if (clr) begin
            sync_q    <= 1'b0;
            wait_sync <= 1'b0;
        end else begin
            sync_q <= sync_in;
            if (start)
                wait_sync <= 1'b1;
            else if (sync_rise)
                wait_sync <= 1'b0;
        end
    end

    // skip/delay frame counter, restarted with the record
    always_ff @(posedge ADC_CLK) begin
        if (clr || rec_start)
            frame_cnt <= 8'd0;
        else if (chan_a.valid)
            frame_cnt <= (frame_cnt == cfg.skip - 8'd1) ? 8'd0 : frame_cnt + 8'd1;
    end

    always_ff @(posedge ADC_CLK) begin
        if (clr) begin
            active  <= 1'b0;
            done    <= 1'b0;
            rec_cnt <= 16'd0;
        end else if (rec_start) begin
            active  <= 1'b1;
            done    <= 1'b0;
            rec_cnt <= 16'd0;
        end else if (accept) begin
            rec_cnt <= rec_cnt + 16'd1;
            if (cfg.data_cnt != 16'd0 && rec_cnt + 16'd1 == cfg.data_cnt) begin
                active <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (clr)
            push <= 1'b0;
        else
            push <= accept;
    end

    always_ff @(posedge ADC_CLK) begin
        if (accept) begin
            if (cfg.pair_mode) begin
                word.pair <= '{fmt: 1'b1, sync: sync_in, tag: rec_cnt[1:0],
                               smp_b: chan_b.data, smp_a: chan_a.data};
            end else begin
                word.single_ch <= '{fmt: 1'b0, sync: sync_in, tag: rec_cnt[1:0],
                                    zero: 13'd0, chan: cfg.chan_sel,
                                    smp: cfg.chan_sel ? chan_b.data : chan_a.data};
            end
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (clr)
            lost_cnt <= 8'd0;
        else if (push && fifo_full && lost_cnt != 8'hff)
            lost_cnt <= lost_cnt + 8'd1;   // word dropped
    end

    assign status.done     = done;
    assign status.lost_cnt = lost_cnt;

endmodule

// File: run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_adc_rx \
    -Mdir obj_dir -o tb_adc_rx -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_adc_rx)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1

// File: tb.f
common/adc_rx_pkg.sv
adc_deser/adc_deser.sv
logic/sample_packer.sv
logic/rx_fifo.sv
logic/adc_rx_regs.sv
logic/adc_rx_top.sv
testbench/tb_adc_rx.sv

// File: testbench/adc_rx_stimulus.txt
# all fields hex: W adr data | F smp_a smp_b sync count | E fmt sync tag b_or_chan a_or_smp
# L fifo_level (waits) | S lost done | C conf data_cnt skip delay | X test_name
W 0 1
W 2 2
W 3 4
W 1 1
F 1a2b 0c3d 0 1
F 2f00 1111 0 1
F 3fff 0001 0 1
F 0555 2aaa 0 1
F 1357 2468 0 1
L 4
E 1 0 0 0c3d 1a2b
E 1 0 1 1111 2f00
E 1 0 2 0001 3fff
E 1 0 3 2aaa 0555
L 0
S 0 1
X pair_mode
W 0 1
W 2 4
W 3 3
W 1 1
F 0111 3abc 0 1
F 0222 0def 0 1
F 0333 2001 0 1
L 3
E 0 0 0 1 3abc
E 0 0 1 1 0def
E 0 0 2 1 2001
S 0 1
X single_chan_b
W 0 1
W 2 2
W 4 3
W 5 1
W 1 1
F 0010 0020 0 1
F 0011 0021 0 1
F 0012 0022 0 1
F 0013 0023 0 1
F 0014 0024 0 1
F 0015 0025 0 1
F 0016 0026 0 1
L 2
E 1 0 0 0021 0011
E 1 0 1 0024 0014
L 0
S 0 0
X skip_delay
W 0 1
W 2 1
W 3 2
W 1 1
F 0aaa 0bbb 0 1
F 0ccc 0ddd 0 1
F 1001 2002 1 1
F 1003 2004 0 1
F 1005 2006 1 1
L 2
E 0 1 0 0 1001
E 0 0 1 0 1003
L 0
S 0 1
X start_with_sync
W 0 1
W 2 2
W 1 1
F 0123 0456 0 44
L 40
S 4 0
X overflow
W 3 1
W 4 2
W 1 1
F 0777 0888 0 1
S 5 1
W 0 1
L 0
S 0 0
C 0 0 1 0
X soft_reset

// File: testbench/tb_adc_rx.sv
module tb_adc_rx;

    localparam int CLK_HALF     = 50;
    localparam int BUS_TIMEOUT  = 16;
    localparam int POLL_LIMIT   = 100;
    localparam int CYC_PER_LINE = 40;

    logic        ADC_CLK;
    logic        RST;
    logic        adc_fco;
    logic        adc_in_a;
    logic        adc_in_b;
    logic        adc_sync;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_wdata;
    logic [31:0] wb_rdata;
    logic        wb_ack;
    logic        lost_error;

    int          test_err;
    int          err_total;
    int          n_tests;
    int          n_failed;
    int          wd_limit;
    string       lines[$];
    logic [31:0] fld [5];   // fields of the current stimulus line

    adc_rx_top u_adc_rx_top (
        .ADC_CLK    (ADC_CLK),
        .RST        (RST),
        .adc_fco    (adc_fco),
        .adc_in_a   (adc_in_a),
        .adc_in_b   (adc_in_b),
        .adc_sync   (adc_sync),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_wdata   (wb_wdata),
        .wb_rdata   (wb_rdata),
        .wb_ack     (wb_ack),
        .lost_error (lost_error)
    );

    initial begin
        ADC_CLK = 1'b0;
        forever #CLK_HALF ADC_CLK = ~ADC_CLK;
    end

    function automatic string trim_line(input string s);
        string t;
        t = s;
        while (t.len() > 0 && (t.getc(t.len() - 1) == 8'h0a || t.getc(t.len() - 1) == 8'h0d
               || t.getc(t.len() - 1) == 8'h20)) begin
            t = t.substr(0, t.len() - 2);
        end
        return t;
    endfunction

    task automatic split_fields(input string line);
        int i;
        for (i = 0; i < 5; i++) begin
            fld[i] = 32'd0;
        end
        fld[3] = 32'd1;   // frame repeat count
        if (line.len() > 2) begin
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
                          fld[0], fld[1], fld[2], fld[3], fld[4]));
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int    fd;
        int    weight;
        string line;
        weight = 0;
        fd = $fopen("testbench/adc_rx_stimulus.txt", "r");
        ok = (fd != 0);
        if (!ok) begin
            $display("cannot open the stimulus file testbench/adc_rx_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            line = trim_line(line);
            if (line.len() == 0 || line.getc(0) == "#")
                continue;
            lines.push_back(line);
            split_fields(line);
            // a frame line weighs as many lines as it repeats
            if (line.getc(0) == "F") begin
                weight += int'(fld[3]);
            end else begin
                weight++;
            end
        end
        $fclose(fd);
        wd_limit = weight * CYC_PER_LINE;
    endtask

    task automatic bus_access(input logic we, input logic [3:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        n = 0;
        @(negedge ADC_CLK);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        do begin
            @(negedge ADC_CLK);
            n++;
        end while (!wb_ack && n < BUS_TIMEOUT);
        if (!wb_ack) begin
            $display("bus access to register %0d was never acknowledged", adr);
            test_err++;
        end else if (n != 1) begin
            $display("ERROR %0t: ack on register %0d came after %0d cycles, expected 1",
                     $time, adr, n);
            test_err++;
        end
        rdata  = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic drive_frame(input adc_rx_pkg::sample_t a, input adc_rx_pkg::sample_t b,
                               input logic sync);
        int i;
        int gap;
        for (i = adc_rx_pkg::SAMPLE_W - 1; i >= 0; i--) begin
            @(negedge ADC_CLK);
            adc_fco  = (i == adc_rx_pkg::SAMPLE_W - 1);   // high on the msb
            adc_in_a = a[i];
            adc_in_b = b[i];
            adc_sync = sync;
        end
        gap = 2 + int'($urandom % 4);
        repeat (gap) begin
            @(negedge ADC_CLK);
            adc_fco  = 1'b0;
            adc_in_a = 1'b0;
            adc_in_b = 1'b0;
        end
    endtask

    function automatic adc_rx_pkg::adc_word_u expect_word();
        adc_rx_pkg::adc_word_u w;
        if (fld[0][0]) begin
            w.pair.fmt   = 1'b1;
            w.pair.sync  = fld[1][0];
            w.pair.tag   = fld[2][1:0];
            w.pair.smp_b = fld[3][13:0];
            w.pair.smp_a = fld[4][13:0];
        end else begin
            w.single_ch.fmt  = 1'b0;
            w.single_ch.sync = fld[1][0];
            w.single_ch.tag  = fld[2][1:0];
            w.single_ch.zero = 13'd0;
            w.single_ch.chan = fld[3][0];
            w.single_ch.smp  = fld[4][13:0];
        end
        return w;
    endfunction

    task automatic check_word(input adc_rx_pkg::adc_word_u got,
                              input adc_rx_pkg::adc_word_u exp);
        if (got !== exp) begin
            if (exp.pair.fmt) begin
                $display("ERROR %0t: pair word %h, expected sync %b tag %0d b %h a %h",
                         $time, got, exp.pair.sync, exp.pair.tag, exp.pair.smp_b,
                         exp.pair.smp_a);
            end else begin
                $display("ERROR %0t: single word %h, expected sync %b tag %0d chan %b smp %h",
                         $time, got, exp.single_ch.sync, exp.single_ch.tag,
                         exp.single_ch.chan, exp.single_ch.smp);
            end
            test_err++;
        end
    endtask

    task automatic check_status(input adc_rx_pkg::rx_status_t got,
                                input adc_rx_pkg::rx_status_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: status lost %0d done %b, expected lost %0d done %b",
                     $time, got.lost_cnt, got.done, exp.lost_cnt, exp.done);
            test_err++;
        end
    endtask

    task automatic check_cfg(input adc_rx_pkg::rx_cfg_t got, input adc_rx_pkg::rx_cfg_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: config %h, expected %h", $time, got, exp);
            test_err++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
            test_err++;
        end
    endtask

    task automatic wait_level(input logic [31:0] exp);
        logic [31:0] rd;
        int          n;
        n = 0;
        do begin
            bus_access(1'b0, adc_rx_pkg::REG_FIFO_LEVEL, 32'd0, rd);
            n++;
        end while (rd != exp && n < POLL_LIMIT);
        if (rd != exp) begin
            $display("FIFO level stayed at %0d while waiting for %0d words", rd, exp);
            test_err++;
        end
    endtask

    task automatic read_status(input adc_rx_pkg::rx_status_t exp);
        logic [31:0]            rd;
        int                     n;
        adc_rx_pkg::rx_status_t got;
        n = 0;
        // lost words land a few cycles after the last frame
        do begin
            bus_access(1'b0, adc_rx_pkg::REG_LOST, 32'd0, rd);
            got.lost_cnt = rd[7:0];
            n++;
        end while (got.lost_cnt != exp.lost_cnt && n < POLL_LIMIT);
        bus_access(1'b0, adc_rx_pkg::REG_START, 32'd0, rd);
        got.done = rd[0];
        check_status(got, exp);
        check_flag("lost_error", lost_error, exp.lost_cnt != 8'd0);
    endtask

    task automatic read_cfg(input adc_rx_pkg::rx_cfg_t exp);
        logic [31:0]         rd;
        adc_rx_pkg::rx_cfg_t got;
        bus_access(1'b0, adc_rx_pkg::REG_CONF, 32'd0, rd);
        got.start_with_sync = rd[0];
        got.pair_mode       = rd[1];
        got.chan_sel        = rd[2];
        bus_access(1'b0, adc_rx_pkg::REG_DATA_CNT, 32'd0, rd);
        got.data_cnt = rd[15:0];
        bus_access(1'b0, adc_rx_pkg::REG_SKIP, 32'd0, rd);
        got.skip = rd[7:0];
        bus_access(1'b0, adc_rx_pkg::REG_DELAY, 32'd0, rd);
        got.delay = rd[7:0];
        check_cfg(got, exp);
    endtask

    task automatic end_test(input string name);
        if (test_err == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_err);
            n_failed++;
        end
        err_total += test_err;
        test_err = 0;
        n_tests++;
    endtask

    task automatic run_stimulus();
        string                  line;
        byte                    cmd;
        logic [31:0]            rd;
        adc_rx_pkg::rx_status_t exp_status;
        adc_rx_pkg::rx_cfg_t    exp_cfg;
        foreach (lines[i]) begin
            line = lines[i];
            cmd  = line.getc(0);
            split_fields(line);
            case (cmd)
                "W": bus_access(1'b1, fld[0][3:0], fld[1], rd);
                "F": begin
                    repeat (fld[3]) drive_frame(fld[0][13:0], fld[1][13:0], fld[2][0]);
                end
                "E": begin
                    bus_access(1'b0, adc_rx_pkg::REG_FIFO_DATA, 32'd0, rd);
                    check_word(rd, expect_word());
                end
                "L": wait_level(fld[0]);
                "S": begin
                    exp_status.lost_cnt = fld[0][7:0];
                    exp_status.done     = fld[1][0];
                    read_status(exp_status);
                end
                "C": begin
                    exp_cfg.start_with_sync = fld[0][0];
                    exp_cfg.pair_mode       = fld[0][1];
                    exp_cfg.chan_sel        = fld[0][2];
                    exp_cfg.data_cnt        = fld[1][15:0];
                    exp_cfg.skip            = fld[2][7:0];
                    exp_cfg.delay           = fld[3][7:0];
                    read_cfg(exp_cfg);
                end
                "X": end_test(line.substr(2, line.len() - 1));
                default: begin
                    $display("unknown command in stimulus line: %s", line);
                    test_err++;
                end
            endcase
        end
    endtask

    initial begin
        wait (wd_limit > 0);
        repeat (wd_limit) @(posedge ADC_CLK);
        $display("timeout: stimulus did not finish within %0d clock cycles", wd_limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        bit ok;
        RST       = 1'b1;
        adc_fco   = 1'b0;
        adc_in_a  = 1'b0;
        adc_in_b  = 1'b0;
        adc_sync  = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = 4'd0;
        wb_wdata  = 32'd0;
        test_err  = 0;
        err_total = 0;
        n_tests   = 0;
        n_failed  = 0;
        void'($urandom(32'h33c3));
        load_stimulus(ok);
        if (!ok) begin
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (5) @(negedge ADC_CLK);
            RST = 1'b0;
            run_stimulus();
            err_total += test_err;   // anything after the last marker
            $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, err_total);
            if (err_total == 0 && n_tests > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule
